// ==== dispatch_top.f ====
hw/core_cfg_pkg.sv
hw/uop_pkg.sv
hw/rename_if.sv
hw/rename_table.sv
hw/phys_regfile.sv
hw/dispatch.sv
hw/rob_alloc.sv
hw/dispatch_top.sv
tb/dispatch_assertions.sv
tb/dispatch_tb.sv

// ==== Bender.yml ====
package:
  name: dispatch_top

sources:
  - files:
      - hw/core_cfg_pkg.sv
      - hw/uop_pkg.sv
      - hw/rename_if.sv
      - hw/rename_table.sv
      - hw/phys_regfile.sv
      - hw/dispatch.sv
      - hw/rob_alloc.sv
      - hw/dispatch_top.sv
  - target: test
    files:
      - tb/dispatch_assertions.sv
      - tb/dispatch_tb.sv

// ==== tb/dispatch_tb.sv ====
`timescale 1ns/1ns

module dispatch_tb;

    localparam int PERIOD     = 40;
    localparam int WAIT_LIMIT = 50;

    logic               clk;
    logic               rst;
    logic               in_valid;
    uop_pkg::uop_code_t in_uop;
    logic               in_eoi;
    uop_pkg::arch_idx_t in_src1_arch;
    uop_pkg::arch_idx_t in_src2_arch;
    uop_pkg::arch_idx_t in_dest_arch;
    uop_pkg::word_t     in_imm;
    logic               in_use_imm;
    uop_pkg::pc_t       in_pc;
    logic               in_except;
    logic               wb_valid;
    uop_pkg::phys_tag_t wb_tag;
    uop_pkg::word_t     wb_val;
    logic               commit_valid;
    logic               in_ready;
    logic               out_valid;
    uop_pkg::uop_code_t out_uop;
    logic               out_eoi;
    logic               op1_rdy;
    logic               op2_rdy;
    uop_pkg::phys_tag_t op1_tag;
    uop_pkg::phys_tag_t op2_tag;
    uop_pkg::word_t     op1_val;
    uop_pkg::word_t     op2_val;
    uop_pkg::phys_tag_t dest_tag;
    uop_pkg::phys_tag_t dest_oldtag;
    uop_pkg::arch_idx_t dest_arch;
    uop_pkg::pc_t       out_pc;
    uop_pkg::rob_idx_t  rob_entry;
    logic               out_except;

    integer seed;
    int     errors = 0;
    int     timeouts = 0;

    // reference model
    uop_pkg::phys_tag_t rat_m [core_cfg_pkg::ARCH_REGS];
    uop_pkg::phys_tag_t fl_m [$];
    logic               rdy_m [core_cfg_pkg::PHYS_REGS];
    uop_pkg::word_t     val_m [core_cfg_pkg::PHYS_REGS];
    logic               rob_dest_m [$];
    uop_pkg::phys_tag_t rob_old_m [$];
    int                 rob_tail_m;

    dispatch_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic uop_pkg::arch_idx_t pick_reg();
        return uop_pkg::arch_idx_t'($random(seed));
    endfunction

    task automatic end_run();
        int asrt;
        asrt = uut.u_checks.fail_count;
        $display("result: %0d mismatches, %0d timeouts, %0d assertion failures",
                 errors, timeouts, asrt);
        if (errors == 0 && timeouts == 0 && asrt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic set_idle();
        in_valid     = 1'b0;
        in_uop       = '0;
        in_eoi       = 1'b0;
        in_src1_arch = '0;
        in_src2_arch = '0;
        in_dest_arch = '0;
        in_imm       = '0;
        in_use_imm   = 1'b0;
        in_pc        = '0;
        in_except    = 1'b0;
        wb_valid     = 1'b0;
        wb_tag       = '0;
        wb_val       = '0;
        commit_valid = 1'b0;
    endtask

    task automatic apply_reset();
        set_idle();
        rst = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        // identity mapping, tags 32..47 free
        for (int i = 0; i < core_cfg_pkg::ARCH_REGS; i++) begin
            rat_m[i] = uop_pkg::phys_tag_t'(i);
        end
        fl_m.delete();
        for (int i = core_cfg_pkg::ARCH_REGS; i < core_cfg_pkg::PHYS_REGS; i++) begin
            fl_m.push_back(uop_pkg::phys_tag_t'(i));
        end
        for (int i = 0; i < core_cfg_pkg::PHYS_REGS; i++) begin
            rdy_m[i] = 1'b1;
            val_m[i] = '0;
        end
        rob_dest_m.delete();
        rob_old_m.delete();
        rob_tail_m = 0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus steps, each starts and ends at a falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic drive_uop(input uop_pkg::arch_idx_t s1, input uop_pkg::arch_idx_t s2,
                             input uop_pkg::arch_idx_t d, input logic use_imm);
        in_valid     = 1'b1;
        in_src1_arch = s1;
        in_src2_arch = s2;
        in_dest_arch = d;
        in_use_imm   = use_imm;
        in_uop       = uop_pkg::uop_code_t'($random(seed));
        in_eoi       = 1'($random(seed));
        in_imm       = $random(seed);
        in_pc        = $random(seed);
        in_except    = 1'($random(seed));
    endtask

    // writeback is visible to a rename in the same cycle
    task automatic drive_wb(input uop_pkg::phys_tag_t t, input uop_pkg::word_t v);
        wb_valid = 1'b1;
        wb_tag   = t;
        wb_val   = v;
        rdy_m[t] = 1'b1;
        val_m[t] = v;
    endtask

    task automatic write_back(input uop_pkg::phys_tag_t t, input uop_pkg::word_t v);
        drive_wb(t, v);
        @(posedge clk);
        @(negedge clk);
        wb_valid = 1'b0;
    endtask

    task automatic commit_one();
        commit_valid = 1'b1;
        // empty rob ignores the commit
        if (rob_dest_m.size() != 0) begin
            if (rob_dest_m.pop_front()) begin
                fl_m.push_back(rob_old_m.pop_front());
            end else begin
                void'(rob_old_m.pop_front());
            end
        end
        @(posedge clk);
        @(negedge clk);
        commit_valid = 1'b0;
    endtask

    task automatic hold_stalled(input int cycles);
        for (int k = 0; k < cycles; k++) begin
            #(PERIOD / 4);
            check_val("in_ready", in_ready, 1'b0);
            @(negedge clk);
            check_val("out_valid", out_valid, 1'b0);
        end
    endtask

    task automatic accept_uop();
        int                 n;
        logic               need;
        logic               r1;
        logic               r2;
        uop_pkg::phys_tag_t t1;
        uop_pkg::phys_tag_t t2;
        uop_pkg::phys_tag_t t_new;
        uop_pkg::phys_tag_t t_old;
        uop_pkg::word_t     v1;
        uop_pkg::word_t     v2;
        n = 0;
        #(PERIOD / 4);
        while (!in_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            #(PERIOD / 4);
            n++;
        end
        if (!in_ready) begin
            timeouts++;
            $display("timeout: in_ready stayed low for %0d cycles", WAIT_LIMIT);
            end_run();
        end else begin
            need  = (in_dest_arch != '0);
            t1    = rat_m[in_src1_arch];
            r1    = rdy_m[t1];
            v1    = val_m[t1];
            t2    = rat_m[in_src2_arch];
            r2    = rdy_m[t2];
            v2    = val_m[t2];
            t_new = need ? fl_m[0] : '0;
            t_old = rat_m[in_dest_arch];
            if (in_use_imm) begin
                r2 = 1'b1;
                t2 = '0;
                v2 = in_imm;
            end
            @(posedge clk);
            @(negedge clk);
            in_valid = 1'b0;
            wb_valid = 1'b0;
            check_val("out_valid", out_valid, 1'b1);
            check_val("op1_tag", op1_tag, t1);
            check_val("op1_rdy", op1_rdy, r1);
            check_val("op1_val", op1_val, v1);
            check_val("op2_tag", op2_tag, t2);
            check_val("op2_rdy", op2_rdy, r2);
            check_val("op2_val", op2_val, v2);
            check_val("dest_tag", dest_tag, t_new);
            check_val("dest_oldtag", dest_oldtag, t_old);
            check_val("dest_arch", dest_arch, in_dest_arch);
            check_val("rob_entry", rob_entry, rob_tail_m);
            check_val("out_uop", out_uop, in_uop);
            check_val("out_pc", out_pc, in_pc);
            check_val("out_eoi", out_eoi, in_eoi);
            check_val("out_except", out_except, in_except);
            if (need) begin
                rat_m[in_dest_arch] = fl_m.pop_front();
                rdy_m[t_new] = 1'b0;
            end
            rob_dest_m.push_back(need);
            rob_old_m.push_back(t_old);
            rob_tail_m = (rob_tail_m + 1) % core_cfg_pkg::ROB_SIZE;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        uop_pkg::arch_idx_t r;
        uop_pkg::arch_idx_t s1;
        uop_pkg::arch_idx_t s2;
        uop_pkg::arch_idx_t d;
        uop_pkg::phys_tag_t wt;
        uop_pkg::word_t     v;
        logic               imm_sel;
        seed = 32'hcf23_42c5;
        rst  = 1'b1;
        set_idle();
        apply_reset();

        // renaming and writeback forwarding
        s1 = pick_reg();
        s2 = pick_reg();
        drive_uop(s1, s2, '0, 1'b0);
        accept_uop();
        r = pick_reg();
        if (r == '0) begin
            r = 5'd1;
        end
        drive_uop(pick_reg(), pick_reg(), r, 1'b0);
        accept_uop();
        drive_uop(r, pick_reg(), '0, 1'b0);
        accept_uop();
        v = $random(seed);
        drive_uop(pick_reg(), r, '0, 1'b0);
        drive_wb(rat_m[r], v);
        accept_uop();
        drive_uop(r, r, '0, 1'b0);
        accept_uop();
        // operand 2 pending, then replaced by the immediate
        drive_uop('0, '0, r, 1'b0);
        accept_uop();
        drive_uop(5'd1, r, '0, 1'b1);
        accept_uop();

        repeat (24) begin
            s1      = pick_reg();
            s2      = pick_reg();
            d       = pick_reg();
            imm_sel = 1'($random(seed));
            if (fl_m.size() == 0) begin
                d = '0;
            end
            drive_uop(s1, s2, d, imm_sel);
            accept_uop();
            if (rob_dest_m.size() >= 24 || 1'($random(seed))) begin
                commit_one();
            end
            if (($random(seed) & 3) == 0) begin
                wt = uop_pkg::phys_tag_t'($unsigned($random(seed)) % core_cfg_pkg::PHYS_REGS);
                v  = $random(seed);
                write_back(wt, v);
            end
        end

        // full rob
        apply_reset();
        commit_one();
        repeat (core_cfg_pkg::ROB_SIZE) begin
            s1 = pick_reg();
            s2 = pick_reg();
            drive_uop(s1, s2, '0, 1'b0);
            accept_uop();
        end
        drive_uop(pick_reg(), pick_reg(), '0, 1'b0);
        hold_stalled(3);
        commit_one();
        accept_uop();

        // empty free list
        apply_reset();
        for (int k = 1; k <= core_cfg_pkg::FREE_TAGS; k++) begin
            drive_uop(pick_reg(), pick_reg(), uop_pkg::arch_idx_t'(k), 1'b0);
            accept_uop();
        end
        drive_uop(pick_reg(), pick_reg(), 5'd20, 1'b0);
        hold_stalled(3);
        commit_one();
        accept_uop();

        repeat (2) @(negedge clk);
        end_run();
    end

endmodule

// ==== tb/dispatch_assertions.sv ====
`timescale 1ns/1ns

module dispatch_assertions (
    input logic               clk,
    input logic               rst,
    input logic               in_valid,
    input logic               in_ready,
    input uop_pkg::uop_code_t in_uop,
    input uop_pkg::arch_idx_t in_src1_arch,
    input uop_pkg::arch_idx_t in_src2_arch,
    input uop_pkg::arch_idx_t in_dest_arch,
    input uop_pkg::word_t     in_imm,
    input logic               in_use_imm,
    input logic               out_valid
);

    int fail_count = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state right after reset
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            $error("out_valid high in the cycle after reset");
            fail_count++;
        end

    a_reset_open: assert property (@(posedge clk) rst |=> in_ready)
        else begin
            $error("in_ready low in the cycle after reset");
            fail_count++;
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // a stalled micro-op stays on the inputs unchanged
    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable(in_uop)
            && $stable(in_src1_arch) && $stable(in_src2_arch)
            && $stable(in_dest_arch) && $stable(in_imm) && $stable(in_use_imm))
        else begin
            $error("stalled input changed before it was accepted");
            fail_count++;
        end

    a_stall_silent: assert property (@(posedge clk) disable iff (rst)
        !in_ready |=> !out_valid)
        else begin
            $error("out_valid high after a cycle with in_ready low");
            fail_count++;
        end

    a_out_from_fire: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(in_valid && in_ready))
        else begin
            $error("out_valid high without an accepted micro-op");
            fail_count++;
        end

endmodule

bind dispatch_top dispatch_assertions u_checks (.*);

// ==== hw/dispatch_top.sv ====
`timescale 1ns/1ns

module dispatch_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  uop_pkg::uop_code_t in_uop,
    input  logic               in_eoi,
    input  uop_pkg::arch_idx_t in_src1_arch,
    input  uop_pkg::arch_idx_t in_src2_arch,
    input  uop_pkg::arch_idx_t in_dest_arch,
    input  uop_pkg::word_t     in_imm,
    input  logic               in_use_imm,
    input  uop_pkg::pc_t       in_pc,
    input  logic               in_except,
    input  logic               wb_valid,
    input  uop_pkg::phys_tag_t wb_tag,
    input  uop_pkg::word_t     wb_val,
    input  logic               commit_valid,
    output logic               in_ready,
    output logic               out_valid,
    output uop_pkg::uop_code_t out_uop,
    output logic               out_eoi,
    output logic               op1_rdy,
    output logic               op2_rdy,
    output uop_pkg::phys_tag_t op1_tag,
    output uop_pkg::phys_tag_t op2_tag,
    output uop_pkg::word_t     op1_val,
    output uop_pkg::word_t     op2_val,
    output uop_pkg::phys_tag_t dest_tag,
    output uop_pkg::phys_tag_t dest_oldtag,
    output uop_pkg::arch_idx_t dest_arch,
    output uop_pkg::pc_t       out_pc,
    output uop_pkg::rob_idx_t  rob_entry,
    output logic               out_except
);

    logic               rob_full;
    uop_pkg::rob_idx_t  rob_tail;
    logic               free_valid;
    uop_pkg::phys_tag_t free_tag;
    uop_pkg::phys_tag_t rd1_tag;
    uop_pkg::phys_tag_t rd2_tag;
    logic               rd1_rdy;
    logic               rd2_rdy;
    uop_pkg::word_t     rd1_val;
    uop_pkg::word_t     rd2_val;
    logic               alloc_valid;
    uop_pkg::phys_tag_t alloc_tag;
    logic               rob_alloc_valid;
    logic               rob_has_dest;
    uop_pkg::phys_tag_t rob_oldtag;

    rename_if rn_bus ();

    rename_table u_rename (
        .clk             (clk),
        .rst             (rst),
        .in_valid        (in_valid),
        .in_uop          (in_uop),
        .in_eoi          (in_eoi),
        .in_src1_arch    (in_src1_arch),
        .in_src2_arch    (in_src2_arch),
        .in_dest_arch    (in_dest_arch),
        .in_imm          (in_imm),
        .in_use_imm      (in_use_imm),
        .in_pc           (in_pc),
        .in_except       (in_except),
        .rob_full        (rob_full),
        .rob_tail        (rob_tail),
        .free_valid      (free_valid),
        .free_tag        (free_tag),
        .rd1_rdy         (rd1_rdy),
        .rd1_val         (rd1_val),
        .rd2_rdy         (rd2_rdy),
        .rd2_val         (rd2_val),
        .in_ready        (in_ready),
        .rd1_tag         (rd1_tag),
        .rd2_tag         (rd2_tag),
        .alloc_valid     (alloc_valid),
        .alloc_tag       (alloc_tag),
        .rob_alloc_valid (rob_alloc_valid),
        .rob_has_dest    (rob_has_dest),
        .rob_oldtag      (rob_oldtag),
        .rn              (rn_bus.src)
    );

    phys_regfile u_prf (
        .clk         (clk),
        .rst         (rst),
        .rd1_tag     (rd1_tag),
        .rd2_tag     (rd2_tag),
        .wb_valid    (wb_valid),
        .wb_tag      (wb_tag),
        .wb_val      (wb_val),
        .alloc_valid (alloc_valid),
        .alloc_tag   (alloc_tag),
        .rd1_rdy     (rd1_rdy),
        .rd1_val     (rd1_val),
        .rd2_rdy     (rd2_rdy),
        .rd2_val     (rd2_val)
    );

    dispatch u_dispatch (
        .clk         (clk),
        .rst         (rst),
        .rob_full    (rob_full),
        .rn          (rn_bus.dst),
        .out_valid   (out_valid),
        .out_uop     (out_uop),
        .out_eoi     (out_eoi),
        .op1_rdy     (op1_rdy),
        .op2_rdy     (op2_rdy),
        .op1_tag     (op1_tag),
        .op2_tag     (op2_tag),
        .op1_val     (op1_val),
        .op2_val     (op2_val),
        .dest_tag    (dest_tag),
        .dest_oldtag (dest_oldtag),
        .dest_arch   (dest_arch),
        .out_pc      (out_pc),
        .rob_entry   (rob_entry),
        .out_except  (out_except)
    );

    rob_alloc u_rob (
        .clk          (clk),
        .rst          (rst),
        .alloc_valid  (rob_alloc_valid),
        .has_dest     (rob_has_dest),
        .oldtag       (rob_oldtag),
        .commit_valid (commit_valid),
        .full         (rob_full),
        .tail         (rob_tail),
        .free_valid   (free_valid),
        .free_tag     (free_tag)
    );

endmodule

// ==== hw/rob_alloc.sv ====
`timescale 1ns/1ns

module rob_alloc (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc_valid,
    input  logic               has_dest,
    input  uop_pkg::phys_tag_t oldtag,
    input  logic               commit_valid,
    output logic               full,
    output uop_pkg::rob_idx_t  tail,
    output logic               free_valid,
    output uop_pkg::phys_tag_t free_tag
);

    uop_pkg::rob_idx_t head;
    logic [core_cfg_pkg::ROB_CNT_W-1:0] count;

    // per-entry bookkeeping for tag release
    logic               ent_has_dest [core_cfg_pkg::ROB_SIZE];
    uop_pkg::phys_tag_t ent_oldtag [core_cfg_pkg::ROB_SIZE];

    logic retire;

    // commit on an empty rob does nothing
    assign retire     = commit_valid && (count != '0);
    assign full       = (count == core_cfg_pkg::ROB_CNT_W'(core_cfg_pkg::ROB_SIZE));
    assign free_valid = retire && ent_has_dest[head];
    assign free_tag   = ent_oldtag[head];

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            ent_has_dest[tail] <= has_dest;
            ent_oldtag[tail]   <= oldtag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_valid) begin
                tail <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            if (alloc_valid && !retire) begin
                count <= count + 1'b1;
            end else if (retire && !alloc_valid) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== hw/dispatch.sv ====
`timescale 1ns/1ns

module dispatch (
    input  logic               clk,
    input  logic               rst,
    input  logic               rob_full,
    rename_if.dst              rn,
    output logic               out_valid,
    output uop_pkg::uop_code_t out_uop,
    output logic               out_eoi,
    output logic               op1_rdy,
    output logic               op2_rdy,
    output uop_pkg::phys_tag_t op1_tag,
    output uop_pkg::phys_tag_t op2_tag,
    output uop_pkg::word_t     op1_val,
    output uop_pkg::word_t     op2_val,
    output uop_pkg::phys_tag_t dest_tag,
    output uop_pkg::phys_tag_t dest_oldtag,
    output uop_pkg::arch_idx_t dest_arch,
    output uop_pkg::pc_t       out_pc,
    output uop_pkg::rob_idx_t  rob_entry,
    output logic               out_except
);

    logic fire;

    // issue never stalls, only the rob can
    assign rn.ready = !rob_full;
    assign fire     = rn.valid && rn.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_uop     <= rn.uop;
            out_eoi     <= rn.eoi;
            op1_rdy     <= rn.src1_rdy;
            op1_tag     <= rn.src1_tag;
            op1_val     <= rn.src1_val;
            // immediate replaces operand 2
            op2_rdy     <= rn.use_imm ? 1'b1 : rn.src2_rdy;
            op2_tag     <= rn.use_imm ? '0 : rn.src2_tag;
            op2_val     <= rn.use_imm ? rn.imm : rn.src2_val;
            dest_tag    <= rn.has_dest ? rn.dest_tag : '0;
            dest_oldtag <= rn.dest_oldtag;
            dest_arch   <= rn.dest_arch;
            out_pc      <= rn.pc;
            rob_entry   <= rn.rob_entry;
            out_except  <= rn.except;
        end
    end

endmodule

// ==== hw/phys_regfile.sv ====
`timescale 1ns/1ns

module phys_regfile (
    input  logic               clk,
    input  logic               rst,
    input  uop_pkg::phys_tag_t rd1_tag,
    input  uop_pkg::phys_tag_t rd2_tag,
    input  logic               wb_valid,
    input  uop_pkg::phys_tag_t wb_tag,
    input  uop_pkg::word_t     wb_val,
    input  logic               alloc_valid,
    input  uop_pkg::phys_tag_t alloc_tag,
    output logic               rd1_rdy,
    output uop_pkg::word_t     rd1_val,
    output logic               rd2_rdy,
    output uop_pkg::word_t     rd2_val
);

    uop_pkg::word_t vals [core_cfg_pkg::PHYS_REGS];
    logic [core_cfg_pkg::PHYS_REGS-1:0] rdy;

    logic hit1;
    logic hit2;

    // writeback bypass into rename
    assign hit1 = wb_valid && (wb_tag == rd1_tag);
    assign hit2 = wb_valid && (wb_tag == rd2_tag);

    assign rd1_rdy = hit1 ? 1'b1 : rdy[rd1_tag];
    assign rd1_val = hit1 ? wb_val : vals[rd1_tag];
    assign rd2_rdy = hit2 ? 1'b1 : rdy[rd2_tag];
    assign rd2_val = hit2 ? wb_val : vals[rd2_tag];

    always_ff @(posedge clk) begin
        if (rst) begin
            rdy <= '1;
            for (int i = 0; i < core_cfg_pkg::PHYS_REGS; i++) begin
                vals[i] <= '0;
            end
        end else begin
            if (wb_valid) begin
                vals[wb_tag] <= wb_val;
                rdy[wb_tag]  <= 1'b1;
            end
            // new producer, result pending
            if (alloc_valid) begin
                rdy[alloc_tag] <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/rename_table.sv ====
`timescale 1ns/1ns

module rename_table (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  uop_pkg::uop_code_t in_uop,
    input  logic               in_eoi,
    input  uop_pkg::arch_idx_t in_src1_arch,
    input  uop_pkg::arch_idx_t in_src2_arch,
    input  uop_pkg::arch_idx_t in_dest_arch,
    input  uop_pkg::word_t     in_imm,
    input  logic               in_use_imm,
    input  uop_pkg::pc_t       in_pc,
    input  logic               in_except,
    input  logic               rob_full,
    input  uop_pkg::rob_idx_t  rob_tail,
    input  logic               free_valid,
    input  uop_pkg::phys_tag_t free_tag,
    input  logic               rd1_rdy,
    input  uop_pkg::word_t     rd1_val,
    input  logic               rd2_rdy,
    input  uop_pkg::word_t     rd2_val,
    output logic               in_ready,
    output uop_pkg::phys_tag_t rd1_tag,
    output uop_pkg::phys_tag_t rd2_tag,
    output logic               alloc_valid,
    output uop_pkg::phys_tag_t alloc_tag,
    output logic               rob_alloc_valid,
    output logic               rob_has_dest,
    output uop_pkg::phys_tag_t rob_oldtag,
    rename_if.src              rn
);

    uop_pkg::phys_tag_t rat [core_cfg_pkg::ARCH_REGS];
    uop_pkg::phys_tag_t fl [core_cfg_pkg::FREE_TAGS];

    logic [core_cfg_pkg::FL_W-1:0]     fl_head;
    logic [core_cfg_pkg::FL_W-1:0]     fl_tail;
    logic [core_cfg_pkg::FL_CNT_W-1:0] fl_count;

    logic need_tag;
    logic tag_ok;
    logic fire;

    // x0 never gets a tag
    assign need_tag = (in_dest_arch != '0);
    assign tag_ok   = !need_tag || (fl_count != '0);

    assign rn.valid = in_valid && tag_ok;
    assign in_ready = rn.ready && tag_ok;
    assign fire     = rn.valid && rn.ready;

    // source lookup, prf answers combinationally
    assign rd1_tag = rat[in_src1_arch];
    assign rd2_tag = rat[in_src2_arch];

    assign rn.uop         = in_uop;
    assign rn.eoi         = in_eoi;
    assign rn.src1_tag    = rd1_tag;
    assign rn.src2_tag    = rd2_tag;
    assign rn.src1_rdy    = rd1_rdy;
    assign rn.src2_rdy    = rd2_rdy;
    assign rn.src1_val    = rd1_val;
    assign rn.src2_val    = rd2_val;
    assign rn.dest_arch   = in_dest_arch;
    assign rn.dest_tag    = fl[fl_head];
    assign rn.dest_oldtag = rat[in_dest_arch];
    assign rn.has_dest    = need_tag;
    assign rn.imm         = in_imm;
    assign rn.use_imm     = in_use_imm;
    assign rn.pc          = in_pc;
    assign rn.except      = in_except;
    assign rn.rob_entry   = rob_tail;

    assign alloc_valid     = fire && need_tag;
    assign alloc_tag       = fl[fl_head];
    assign rob_alloc_valid = fire;
    assign rob_has_dest    = need_tag;
    assign rob_oldtag      = rat[in_dest_arch];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alias table and free list
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < core_cfg_pkg::ARCH_REGS; i++) begin
                rat[i] <= uop_pkg::phys_tag_t'(i);
            end
            for (int i = 0; i < core_cfg_pkg::FREE_TAGS; i++) begin
                fl[i] <= uop_pkg::phys_tag_t'(core_cfg_pkg::ARCH_REGS + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= core_cfg_pkg::FL_CNT_W'(core_cfg_pkg::FREE_TAGS);
        end else begin
            if (alloc_valid) begin
                rat[in_dest_arch] <= fl[fl_head];
                fl_head           <= fl_head + 1'b1;
            end
            // committed tags go to the back
            if (free_valid) begin
                fl[fl_tail] <= free_tag;
                fl_tail     <= fl_tail + 1'b1;
            end
            if (free_valid && !alloc_valid) begin
                fl_count <= fl_count + 1'b1;
            end else if (alloc_valid && !free_valid) begin
                fl_count <= fl_count - 1'b1;
            end
        end
    end

endmodule

// ==== hw/rename_if.sv ====
`timescale 1ns/1ns

interface rename_if;

    logic                valid;
    logic                ready;
    uop_pkg::uop_code_t  uop;
    logic                eoi;
    logic                src1_rdy;
    logic                src2_rdy;
    uop_pkg::phys_tag_t  src1_tag;
    uop_pkg::phys_tag_t  src2_tag;
    uop_pkg::word_t      src1_val;
    uop_pkg::word_t      src2_val;
    uop_pkg::arch_idx_t  dest_arch;
    uop_pkg::phys_tag_t  dest_tag;
    uop_pkg::phys_tag_t  dest_oldtag;
    logic                has_dest;
    uop_pkg::word_t      imm;
    logic                use_imm;
    uop_pkg::pc_t        pc;
    logic                except;
    uop_pkg::rob_idx_t   rob_entry;

    // rename side
    modport src (
        output valid, uop, eoi, src1_rdy, src2_rdy, src1_tag, src2_tag,
               src1_val, src2_val, dest_arch, dest_tag, dest_oldtag, has_dest,
               imm, use_imm, pc, except, rob_entry,
        input  ready
    );

    // dispatch side
    modport dst (
        input  valid, uop, eoi, src1_rdy, src2_rdy, src1_tag, src2_tag,
               src1_val, src2_val, dest_arch, dest_tag, dest_oldtag, has_dest,
               imm, use_imm, pc, except, rob_entry,
        output ready
    );

endinterface

// ==== hw/uop_pkg.sv ====
package uop_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // micro-op field types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // physical register tag
    typedef logic [core_cfg_pkg::TAG_W-1:0] phys_tag_t;

    // architectural register index, 0 is the zero register
    typedef logic [core_cfg_pkg::ARCH_W-1:0] arch_idx_t;

    // reorder buffer slot
    typedef logic [core_cfg_pkg::ROB_W-1:0] rob_idx_t;

    // operand and result data
    typedef logic [core_cfg_pkg::XLEN-1:0] word_t;

    // opcode handed to issue
    typedef logic [core_cfg_pkg::UOP_W-1:0] uop_code_t;

    // program counter, same width as a data word
    typedef logic [core_cfg_pkg::XLEN-1:0] pc_t;

endpackage

// ==== hw/core_cfg_pkg.sv ====
package core_cfg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // machine sizing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int XLEN      = 32;
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 48;
    localparam int ROB_SIZE  = 32;
    localparam int NUM_UOPS  = 32;

    // tags beyond the initial identity mapping
    localparam int FREE_TAGS = PHYS_REGS - ARCH_REGS;

    // derived widths
    localparam int TAG_W     = $clog2(PHYS_REGS);
    localparam int ARCH_W    = $clog2(ARCH_REGS);
    localparam int ROB_W     = $clog2(ROB_SIZE);
    localparam int ROB_CNT_W = $clog2(ROB_SIZE + 1);
    localparam int UOP_W     = $clog2(NUM_UOPS);
    localparam int FL_W      = $clog2(FREE_TAGS);
    localparam int FL_CNT_W  = $clog2(FREE_TAGS + 1);

endpackage
